// ==== logic/simd_mult_pkg.sv ====
// Shared types for the packed-SIMD signed multiplier
// Operation codes, kernel modes, the lane view of a word and lane constants

package simd_mult_pkg;

  // Lane geometry
  localparam int unsigned BYTE_W         = 8;
  localparam int unsigned HALF_W         = 16;
  localparam int unsigned NUM_BYTE_LANES = 4;

  // Saturation values for Q7 and Q15 lanes
  localparam logic [BYTE_W-1:0] Q7_MAX  = 8'h7f;
  localparam logic [HALF_W-1:0] Q15_MAX = 16'h7fff;

  // Operation code
  typedef enum logic [2:0] {
    OP_KHM8   = 3'd0,
    OP_KHMX8  = 3'd1,
    OP_KHM16  = 3'd2,
    OP_KHMX16 = 3'd3,
    OP_SMBB16 = 3'd4,
    OP_SMTT16 = 3'd5,
    OP_MUL    = 3'd6
  } simd_op_e;

  // Kernel mode, the two M32 values are the two MUL phases
  typedef enum logic [1:0] {
    M8X8      = 2'd0,
    M16X16    = 2'd1,
    M32_LO    = 2'd2,
    M32_CROSS = 2'd3
  } mult_mode_e;

  // One operand word, seen as byte lanes or halfword lanes
  typedef union packed {
    logic [NUM_BYTE_LANES-1:0][BYTE_W-1:0] byte_lane;
    logic [1:0][HALF_W-1:0]                half_lane;
    logic [31:0]                           word;
  } simd_word_u;

  // Eight signed 9x9 products, index 4*kernel + 2*a_slot + b_slot
  typedef logic [7:0][17:0] kernel_prod_t;

endpackage

// ==== logic/byte_kernel_array.sv ====
// Byte kernel array
// Two 16x16 kernels of four signed 9x9 multipliers each, with quadrant
// steering of the B bytes and a per-mode sign decode

`timescale 1ns/1ns

module byte_kernel_array import simd_mult_pkg::*; (
  input  mult_mode_e   mode_i,
  input  logic         crossed_i,
  input  simd_word_u   a_i,
  input  simd_word_u   b_i,
  output kernel_prod_t prod_o
);

  // Operand bytes per slot, index 2*kernel + slot
  logic [NUM_BYTE_LANES-1:0][BYTE_W-1:0] op_a;
  logic [NUM_BYTE_LANES-1:0][BYTE_W-1:0] op_b;
  logic [NUM_BYTE_LANES-1:0]             sign_a;
  logic [NUM_BYTE_LANES-1:0]             sign_b;
  logic                                  swap;

  //////////////////////////////////////////////////////////////////////
  // Quadrant select
  //////////////////////////////////////////////////////////////////////

  // Crossed halfwords and the second MUL phase swap the B halves
  assign swap = (mode_i == M32_CROSS) || ((mode_i == M16X16) && crossed_i);

  // Kernel 0 always sees the low A half, kernel 1 the high half
  assign op_a = a_i.byte_lane;

  assign op_b[0] = swap ? b_i.byte_lane[2] : b_i.byte_lane[0];
  assign op_b[1] = swap ? b_i.byte_lane[3] : b_i.byte_lane[1];
  assign op_b[2] = swap ? b_i.byte_lane[0] : b_i.byte_lane[2];
  assign op_b[3] = swap ? b_i.byte_lane[1] : b_i.byte_lane[3];

  //////////////////////////////////////////////////////////////////////
  // Sign decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (mode_i)
      // Every byte is a signed Q7 value
      M8X8: begin
        sign_a = {op_a[3][BYTE_W-1], op_a[2][BYTE_W-1],
                  op_a[1][BYTE_W-1], op_a[0][BYTE_W-1]};
        sign_b = {op_b[3][BYTE_W-1], op_b[2][BYTE_W-1],
                  op_b[1][BYTE_W-1], op_b[0][BYTE_W-1]};
      end
      // Only the upper byte of a halfword carries a sign
      M16X16: begin
        sign_a = {op_a[3][BYTE_W-1], 1'b0, op_a[1][BYTE_W-1], 1'b0};
        sign_b = {op_b[3][BYTE_W-1], 1'b0, op_b[1][BYTE_W-1], 1'b0};
      end
      // Low word of a 32x32 product, signs do not reach it
      M32_LO, M32_CROSS: begin
        sign_a = '0;
        sign_b = '0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // 9x9 multipliers
  //////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < 2; k++) begin : g_kernel
    for (genvar i = 0; i < 2; i++) begin : g_a_slot
      for (genvar j = 0; j < 2; j++) begin : g_b_slot
        assign prod_o[4*k + 2*i + j] =
            $signed({sign_a[2*k + i], op_a[2*k + i]}) *
            $signed({sign_b[2*k + j], op_b[2*k + j]});
      end
    end
  end

endmodule

// ==== logic/halfword_adder.sv ====
// Halfword adder
// Aligns the four byte products of each kernel into a 32-bit product and
// sums the crossed products during the second MUL phase

`timescale 1ns/1ns

module halfword_adder import simd_mult_pkg::*; (
  input  kernel_prod_t prod_i,
  input  mult_mode_e   mode_i,
  output logic [31:0]  half_prod0_o,
  output logic [31:0]  half_prod1_o
);

  logic signed [31:0] ext [8];
  logic signed [31:0] mid_sum [2];
  logic [1:0][31:0]   kern_sum;
  logic [31:0]        cross_sum;

  // Sign extend each 18-bit partial product
  for (genvar i = 0; i < 8; i++) begin : g_ext
    assign ext[i] = $signed(prod_i[i]);
  end

  //////////////////////////////////////////////////////////////////////
  // Kernel sums
  //////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < 2; k++) begin : g_kernel
    // Middle terms share the byte weight
    assign mid_sum[k] = ext[4*k + 1] + ext[4*k + 2];

    assign kern_sum[k] = ext[4*k]
                       + (mid_sum[k] <<< BYTE_W)
                       + (ext[4*k + 3] <<< HALF_W);
  end

  // Both crossed halves for the MUL high term
  assign cross_sum = kern_sum[0] + kern_sum[1];

  assign half_prod0_o = (mode_i == M32_CROSS) ? cross_sum : kern_sum[0];
  assign half_prod1_o = kern_sum[1];

endmodule

// ==== logic/lane_result.sv ====
// Lane result stage
// Picks the Q7 or Q15 field per lane, saturates the -1 x -1 case and
// selects the word that belongs to the operation

`timescale 1ns/1ns

module lane_result import simd_mult_pkg::*; (
  input  simd_op_e     op_i,
  input  simd_word_u   a_i,
  input  simd_word_u   b_i,
  input  kernel_prod_t prod_i,
  input  logic [31:0]  half_prod0_i,
  input  logic [31:0]  half_prod1_i,
  output simd_word_u   lane_word_o,
  output logic         sat_o
);

  logic                                  crossed;
  logic [NUM_BYTE_LANES-1:0][BYTE_W-1:0] q7;
  logic [NUM_BYTE_LANES-1:0]             sat8;
  logic [1:0][HALF_W-1:0]                q15;
  logic [1:0]                            sat16;
  logic [1:0][31:0]                      half_prod;

  assign crossed   = (op_i == OP_KHMX8) || (op_i == OP_KHMX16);
  assign half_prod = {half_prod1_i, half_prod0_i};

  //////////////////////////////////////////////////////////////////////
  // Q7 byte lanes
  //////////////////////////////////////////////////////////////////////

  for (genvar n = 0; n < NUM_BYTE_LANES; n++) begin : g_byte
    // Lane n lives in kernel n/2, crossed uses the other B slot
    localparam int str_idx = 4*(n/2) + 3*(n%2);
    localparam int crs_idx = 4*(n/2) + 1 + (n%2);

    logic [17:0]       prod;
    logic [BYTE_W-1:0] b_op;

    assign prod    = crossed ? prod_i[crs_idx] : prod_i[str_idx];
    assign b_op    = crossed ? b_i.byte_lane[n ^ 1] : b_i.byte_lane[n];
    assign sat8[n] = (a_i.byte_lane[n] == 8'h80) && (b_op == 8'h80);
    assign q7[n]   = sat8[n] ? Q7_MAX : prod[14:7];
  end

  //////////////////////////////////////////////////////////////////////
  // Q15 halfword lanes
  //////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < 2; k++) begin : g_half
    logic [HALF_W-1:0] b_op;

    assign b_op     = crossed ? b_i.half_lane[k ^ 1] : b_i.half_lane[k];
    assign sat16[k] = (a_i.half_lane[k] == 16'h8000) && (b_op == 16'h8000);
    assign q15[k]   = sat16[k] ? Q15_MAX : half_prod[k][30:15];
  end

  // Result select
  always_comb begin
    lane_word_o.word = '0;
    sat_o            = 1'b0;
    unique case (op_i)
      OP_KHM8, OP_KHMX8: begin
        lane_word_o.byte_lane = q7;
        sat_o                 = |sat8;
      end
      OP_KHM16, OP_KHMX16: begin
        lane_word_o.half_lane = q15;
        sat_o                 = |sat16;
      end
      OP_SMBB16: lane_word_o.word = half_prod0_i;
      OP_SMTT16: lane_word_o.word = half_prod1_i;
      // MUL is finished in the sequencer
      default:   lane_word_o.word = '0;
    endcase
  end

endmodule

// ==== logic/mult_sequencer.sv ====
// Multiplier sequencer
// Decodes the operation into a kernel mode, runs the two MUL phases and
// registers the result, the saturation flag and the valid strobe

`timescale 1ns/1ns

module mult_sequencer import simd_mult_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        start_i,
  input  simd_op_e    op_i,
  input  simd_word_u  a_i,
  input  simd_word_u  b_i,
  input  simd_word_u  lane_word_i,
  input  logic        lane_sat_i,
  input  logic [31:0] half_prod0_i,
  output mult_mode_e  mode_o,
  output logic        crossed_o,
  output simd_word_u  kern_a_o,
  output simd_word_u  kern_b_o,
  output logic        busy_o,
  output logic        valid_o,
  output simd_word_u  result_o,
  output logic        sat_o
);

  typedef enum logic {IDLE, CROSS} phase_e;

  phase_e      state_q;
  phase_e      state_d;
  simd_word_u  a_q;
  simd_word_u  b_q;
  logic [31:0] part_q;
  logic        issue_mul;
  logic        issue_lane;
  logic        finish;
  simd_word_u  result_d;

  assign issue_mul  = start_i && (state_q == IDLE) && (op_i == OP_MUL);
  assign issue_lane = start_i && (state_q == IDLE) && (op_i != OP_MUL);
  assign finish     = issue_lane || (state_q == CROSS);

  assign state_d = issue_mul ? CROSS : IDLE;
  assign busy_o  = (state_q == CROSS);

  ////////////////////////////////////////////////////////////////////
  // Mode decode and kernel operands
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    mode_o    = M8X8;
    crossed_o = 1'b0;
    kern_a_o  = a_i;
    kern_b_o  = b_i;
    if (state_q == CROSS) begin
      // Cross terms of the captured MUL operands
      mode_o    = M32_CROSS;
      crossed_o = 1'b1;
      kern_a_o  = a_q;
      kern_b_o  = b_q;
    end else begin
      unique case (op_i)
        OP_KHM8:   mode_o = M8X8;
        OP_KHMX8: begin
          mode_o    = M8X8;
          crossed_o = 1'b1;
        end
        OP_KHMX16: begin
          mode_o    = M16X16;
          crossed_o = 1'b1;
        end
        OP_MUL:    mode_o = M32_LO;
        default:   mode_o = M16X16;
      endcase
    end
  end

  // MUL low word adds the cross sum one halfword up
  assign result_d.word = (state_q == CROSS) ? part_q + {half_prod0_i[15:0], 16'h0000}
                                            : lane_word_i.word;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      valid_o <= 1'b0;
      sat_o   <= 1'b0;
    end else begin
      state_q <= state_d;
      valid_o <= finish;
      sat_o   <= issue_lane && lane_sat_i;
    end
  end

  // Operand capture and result registers
  always_ff @(posedge clk_i) begin
    if (issue_mul) begin
      a_q    <= a_i;
      b_q    <= b_i;
      part_q <= half_prod0_i;
    end
    if (finish) begin
      result_o <= result_d;
    end
  end

endmodule

// ==== logic/simd_mult.sv ====
// Packed-SIMD signed multiplier
// Q7 and Q15 saturating lane multiplies, halfword products and a
// two-cycle 32x32 low-word multiply on eight 8x8 kernels

`timescale 1ns/1ns

module simd_mult import simd_mult_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  simd_op_e   op_i,
  input  simd_word_u a_i,
  input  simd_word_u b_i,
  output simd_word_u result_o,
  output logic       sat_o,
  output logic       valid_o,
  output logic       busy_o
);

  mult_mode_e   mode;
  logic         crossed;
  simd_word_u   kern_a;
  simd_word_u   kern_b;
  kernel_prod_t prod;
  logic [31:0]  half_prod0;
  logic [31:0]  half_prod1;
  simd_word_u   lane_word;
  logic         lane_sat;

  ////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////

  byte_kernel_array u_kernels (
    .mode_i    (mode),
    .crossed_i (crossed),
    .a_i       (kern_a),
    .b_i       (kern_b),
    .prod_o    (prod)
  );

  halfword_adder u_adder (
    .prod_i       (prod),
    .mode_i       (mode),
    .half_prod0_o (half_prod0),
    .half_prod1_o (half_prod1)
  );

  lane_result u_lanes (
    .op_i         (op_i),
    .a_i          (kern_a),
    .b_i          (kern_b),
    .prod_i       (prod),
    .half_prod0_i (half_prod0),
    .half_prod1_i (half_prod1),
    .lane_word_o  (lane_word),
    .sat_o        (lane_sat)
  );

  // Control and output registers
  mult_sequencer u_seq (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .op_i         (op_i),
    .a_i          (a_i),
    .b_i          (b_i),
    .lane_word_i  (lane_word),
    .lane_sat_i   (lane_sat),
    .half_prod0_i (half_prod0),
    .mode_o       (mode),
    .crossed_o    (crossed),
    .kern_a_o     (kern_a),
    .kern_b_o     (kern_b),
    .busy_o       (busy_o),
    .valid_o      (valid_o),
    .result_o     (result_o),
    .sat_o        (sat_o)
  );

endmodule

// ==== bench/clk_gen.sv ====
// Clock and reset source for the multiplier testbench
// Free running clock and an active low reset held for a few cycles

`timescale 1ns/1ns

module clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset released on a rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// ==== bench/simd_mult_assertions.sv ====
// Protocol assertions for the SIMD multiplier
// Start only while idle, fixed result latency per operation class

`timescale 1ns/1ns

module simd_mult_assertions import simd_mult_pkg::*; (
  input logic     clk_i,
  input logic     rst_ni,
  input logic     start_i,
  input simd_op_e op_i,
  input logic     busy_i,
  input logic     valid_i
);

  logic lane_start;
  logic mul_start;

  assign lane_start = start_i && !busy_i && (op_i != OP_MUL);
  assign mul_start  = start_i && !busy_i && (op_i == OP_MUL);

  // No new operation during the MUL cross phase
  no_start_when_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni) busy_i |-> !start_i
  ) else $error("start_i asserted while busy_o is high");

  // Lane operations answer in the next cycle
  lane_latency: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $past(lane_start) |-> valid_i
  ) else $error("valid_o missing one cycle after a lane operation start");

  // MUL answers after both phases
  mul_latency: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $past(mul_start, 2) |-> valid_i
  ) else $error("valid_o missing two cycles after a MUL start");

endmodule

// ==== bench/tb_simd_mult.sv ====
// Testbench for the packed-SIMD signed multiplier
// Replays the stimulus file, adds random MUL vectors and checks each result

`timescale 1ns/1ns

module tb_simd_mult import simd_mult_pkg::*; ();

  localparam int    CLK_PERIOD   = 40;
  localparam int    RESET_CYCLES = 4;
  localparam int    NUM_RANDOM   = 4;
  localparam string STIM_FILE    = "bench/simd_mult_stim.txt";

  logic       clk;
  logic       rst_n;
  logic       start;
  simd_op_e   op;
  simd_word_u a;
  simd_word_u b;
  simd_word_u result;
  logic       sat;
  logic       valid;
  logic       busy;

  // Vectors read from the stimulus file
  simd_op_e   vec_op [$];
  simd_word_u vec_a [$];
  simd_word_u vec_b [$];
  simd_word_u vec_res [$];
  logic       vec_sat [$];
  bit         vectors_loaded = 1'b0;

  // Outstanding results, oldest first
  simd_word_u exp_res_q [$];
  logic       exp_sat_q [$];
  int         exp_idx_q [$];
  int         issued   = 0;
  int         received = 0;
  integer     seed;

  clk_gen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  simd_mult dut (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .start_i  (start),
    .op_i     (op),
    .a_i      (a),
    .b_i      (b),
    .result_o (result),
    .sat_o    (sat),
    .valid_o  (valid),
    .busy_o   (busy)
  );

  bind simd_mult simd_mult_assertions u_assertions (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (start_i),
    .op_i    (op_i),
    .busy_i  (busy_o),
    .valid_i (valid_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_result(input simd_word_u got, input simd_word_u want, input int idx);
    if (got.word !== want.word) begin
      $display("** Error at %0t ns: operation %0d returned %08h, expected %08h",
               $time, idx, got.word, want.word);
      $display("SIMULATION FAILED");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_sat(input logic got, input logic want, input int idx);
    if (got !== want) begin
      $display("** Error at %0t ns: operation %0d saturation flag %b, expected %b",
               $time, idx, got, want);
      $display("SIMULATION FAILED");
      $fatal(1, "saturation flag mismatch");
    end
  endtask

  task automatic check_busy(input logic got, input logic want, input int idx);
    if (got !== want) begin
      $display("** Error at %0t ns: operation %0d busy flag %b, expected %b",
               $time, idx, got, want);
      $display("SIMULATION FAILED");
      $fatal(1, "busy flag mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  task automatic load_vectors();
    int          fd;
    int          count;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_res;
    logic [31:0] f_sat;
    simd_word_u  word;

    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file %s", STIM_FILE);
      $display("SIMULATION FAILED");
      $fatal(1, "missing stimulus file");
    end else begin
      // Comment lines do not scan as five hex fields
      while ($fgets(line, fd) != 0) begin
        count = $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_res, f_sat);
        if (count == 5) begin
          vec_op.push_back(simd_op_e'(f_op[2:0]));
          word.word = f_a;
          vec_a.push_back(word);
          word.word = f_b;
          vec_b.push_back(word);
          word.word = f_res;
          vec_res.push_back(word);
          vec_sat.push_back(f_sat[0]);
        end
      end
      $fclose(fd);
      vectors_loaded = 1'b1;
    end
  endtask

  // MUL cross phase keeps busy_o high for exactly one cycle
  task automatic wait_idle(input int idx);
    @(negedge clk);
    check_busy(busy, 1'b1, idx);
    @(negedge clk);
    check_busy(busy, 1'b0, idx);
  endtask

  task automatic issue_vector(input simd_op_e v_op, input simd_word_u v_a,
                              input simd_word_u v_b, input simd_word_u v_res,
                              input logic v_sat);
    @(posedge clk);
    start <= 1'b1;
    op    <= v_op;
    a     <= v_a;
    b     <= v_b;
    exp_res_q.push_back(v_res);
    exp_sat_q.push_back(v_sat);
    exp_idx_q.push_back(issued);
    issued++;
    if (v_op == OP_MUL) begin
      @(posedge clk);
      start <= 1'b0;
      wait_idle(issued - 1);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Processes
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    simd_word_u ra;
    simd_word_u rb;
    simd_word_u rr;

    start = 1'b0;
    op    = OP_KHM8;
    a     = '0;
    b     = '0;
    seed  = 32'h3c8dd0e7;
    load_vectors();
    while (rst_n !== 1'b1) @(posedge clk);

    // File vectors, lane operations run back to back
    foreach (vec_op[i]) begin
      issue_vector(vec_op[i], vec_a[i], vec_b[i], vec_res[i], vec_sat[i]);
    end

    for (int i = 0; i < NUM_RANDOM; i++) begin
      ra.word = $random(seed);
      rb.word = $random(seed);
      // Low word of the full product
      rr.word = ra.word * rb.word;
      issue_vector(OP_MUL, ra, rb, rr, 1'b0);
    end

    @(posedge clk);
    start <= 1'b0;
    while (received != issued) @(negedge clk);
    // Stray valid_o pulses after the last result
    repeat (2) @(negedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

  // Outputs are sampled mid cycle
  always @(negedge clk) begin : monitor
    simd_word_u want_res;
    logic       want_sat;
    int         idx;

    if (rst_n === 1'b1 && valid === 1'b1) begin
      if (exp_res_q.size() == 0) begin
        $display("valid_o pulsed at %0t ns with no operation outstanding", $time);
        $display("SIMULATION FAILED");
        $fatal(1, "unexpected result");
      end else begin
        want_res = exp_res_q.pop_front();
        want_sat = exp_sat_q.pop_front();
        idx      = exp_idx_q.pop_front();
        check_result(result, want_res, idx);
        check_sat(sat, want_sat, idx);
        received++;
      end
    end
  end

  initial begin : watchdog
    int limit_ns;

    wait (vectors_loaded);
    limit_ns = (vec_op.size() + NUM_RANDOM + 4) * 3 * CLK_PERIOD
             + RESET_CYCLES * CLK_PERIOD;
    #(limit_ns);
    $display("Timeout: the run did not complete within %0d ns", limit_ns);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== bench/simd_mult_stim.txt ====
// Columns: op a b expected_result expected_sat, all hex
// op codes: 0 KHM8, 1 KHMX8, 2 KHM16, 3 KHMX16, 4 SMBB16, 5 SMTT16, 6 MUL
0 8020c080 8040407f 7f10e081 1
0 03ff05fd 7f7f8190 02fffb02 0
1 40201008 70c0907f e01c0ff9 0
1 7f818000 12348080 33ee7f00 1
1 00000180 00000180 0000ffff 0
6 12345678 9abcdef0 242d2080 0
2 8000c000 80007fff 7fffc000 1
2 1234f00d 056789ab 00c40ebe 0
3 80008000 7fff8000 7fff8001 1
3 7fff8000 40008000 8001c000 0
3 0100ff00 20000300 0006ffc0 0
6 ffffffff ffffffff 00000001 0
4 12348000 56788000 40000000 0
4 aaaafffd bbbb0007 ffffffeb 0
5 7fff0000 80001111 c0008000 0
5 12345678 05679abc 006256ec 0
6 fffffffe 00000007 fffffff2 0
6 00010001 00010001 00020001 0

// ==== all.f ====
logic/simd_mult_pkg.sv
logic/byte_kernel_array.sv
logic/halfword_adder.sv
logic/lane_result.sv
logic/mult_sequencer.sv
logic/simd_mult.sv
bench/clk_gen.sv
bench/simd_mult_assertions.sv
bench/tb_simd_mult.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SIMD multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_simd_mult; then
  echo "Verilator build failed"
  exit 1
fi

if ! output=$(./obj_dir/Vtb_simd_mult); then
  printf '%s\n' "$output"
  echo "Simulation exited with an error status"
  exit 1
fi
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "^SIMULATION PASSED$"; then
  exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
